// File: verilog/scan_pkg.sv
package scan_pkg;

   // Stream identifier width and the number of streams tracked
   localparam int STREAM_W = 6;
   localparam int NUM_STREAMS = 1 << STREAM_W;

   // One character per cycle on the byte path
   localparam int CHAR_W = 8;

   // Matcher state counts matched prefix characters
   // Wide enough for any pattern up to MAX_PAT_LEN
   localparam int STATE_W = 4;
   localparam int MAX_PAT_LEN = 8;

   // End-of-packet match counters
   localparam int COUNT_W = 16;

   // Patterns are right aligned in MAX_PAT_LEN bytes
   // First character sits in the highest used byte, as a string literal packs
   // Bytes above the pattern length are zero
   localparam logic [CHAR_W*MAX_PAT_LEN-1:0] PATTERN_A = "GET ";
   localparam int PATTERN_A_LEN = 4;

   // Second engine looks for a different literal
   localparam logic [CHAR_W*MAX_PAT_LEN-1:0] PATTERN_B = "evil";
   localparam int PATTERN_B_LEN = 4;

   // Engine enable vector, one bit per engine
   // Bit 0 feeds engine A, bit 1 feeds engine B
   localparam int NUM_ENGINES = 2;

   // Framer countdown from the last character to eop
   // Value loaded when the end marker leaves the byte pipeline
   localparam int EOP_DELAY = 2;

   // Countdown register width
   localparam int EOP_CNT_W = 2;

endpackage

// File: verilog/literal_dfa.sv
module literal_dfa
   import scan_pkg::*;
#(
   parameter logic [CHAR_W*MAX_PAT_LEN-1:0] PATTERN = '0,
   parameter int PAT_LEN = 1
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [CHAR_W-1:0]  char_in,
   input  logic               char_vld,
   input  logic [STATE_W-1:0] state_in,
   input  logic               state_in_vld,
   output logic [STATE_W-1:0] state_out,
   output logic               accept
);

   // Pattern characters in matching order, index 0 is the first one
   logic [CHAR_W-1:0]  pat_chars [MAX_PAT_LEN];

   // Matched-prefix length
   logic [STATE_W-1:0] state_q;
   logic [STATE_W-1:0] state_d;

   // Character expected next for the current prefix
   logic [CHAR_W-1:0]  next_char;
   logic               match_next;
   logic               first_hit;
   logic               hit_last;

   // Unpack the right-aligned pattern into a character table
   for (genvar i = 0; i < MAX_PAT_LEN; i++)
   begin : g_pat
      if (i < PAT_LEN)
      begin : g_used
         assign pat_chars[i] = PATTERN[CHAR_W*(PAT_LEN-1-i) +: CHAR_W];
      end
      else
      begin : g_unused
         assign pat_chars[i] = '0;
      end
   end

   // Select the expected character by the current state
   always_comb
   begin
      next_char = '0;
      for (int i = 0; i < MAX_PAT_LEN; i++)
      begin
         if (state_q == STATE_W'(i))
            next_char = pat_chars[i];
      end
   end

   // Matching rule
   // A miss falls back to 1 only if the character restarts the pattern
   // This is exact because the first character never recurs in the string
   always_comb
   begin
      match_next = (char_in == next_char);
      first_hit  = (char_in == pat_chars[0]);
      hit_last   = match_next && (state_q == STATE_W'(PAT_LEN - 1));
      if (hit_last)
         state_d = '0;
      else if (match_next)
         state_d = state_q + STATE_W'(1);
      else if (first_hit)
         state_d = STATE_W'(1);
      else
         state_d = '0;
   end

   // State register and registered accept pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         accept  <= 1'b0;
      end
      else
      begin
         accept <= 1'b0;
         // Restore wins over a character in the same cycle
         if (state_in_vld)
            state_q <= state_in;
         else if (char_vld)
         begin
            state_q <= state_d;
            accept  <= hit_last;
         end
      end
   end

   assign state_out = state_q;

endmodule

// File: verilog/stream_context_scanner.sv
module stream_context_scanner
   import scan_pkg::*;
#(
   parameter logic [CHAR_W*MAX_PAT_LEN-1:0] PATTERN = '0,
   parameter int PAT_LEN = 1
)
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load_state,
   input  logic                new_stream,
   input  logic [STREAM_W-1:0] stream_id,
   input  logic [CHAR_W-1:0]   char_in,
   input  logic                char_vld,
   input  logic                eop,
   input  logic                enable,
   output logic [COUNT_W-1:0]  count,
   output logic                fired
);

   // Saved matcher state per stream
   logic [STATE_W-1:0] state_mem [NUM_STREAMS];

   // Restore path into the matcher
   logic [STATE_W-1:0] state_in;
   logic               state_in_vld;

   // Matcher outputs
   logic [STATE_W-1:0] state_out;
   logic               accept;

   // Sticky per-packet match flag
   logic               spec_match;

   // Save the live state at end of packet for enabled engines
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   // Restore register
   // New streams start from zero, others pick up their saved state
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream)
            state_in <= '0;
         else
            state_in <= state_mem[stream_id];
      end
   end

   // One-cycle load strobe into the matcher
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // Match flag and count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_match <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Cleared at the start of every packet
         if (load_state)
            spec_match <= 1'b0;

         // Any accept inside the packet sets it
         if (accept)
            spec_match <= 1'b1;

         // Finalize at end of packet
         if (eop)
         begin
            if (enable)
               count <= count + COUNT_W'(spec_match);
            else
               // Disabled engine reports nothing for this packet
               spec_match <= 1'b0;
         end
      end
   end

   assign fired = spec_match;

   literal_dfa #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   ) dfa0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_vld     (char_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

endmodule

// File: verilog/packet_framer.sv
module packet_framer
   import scan_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pkt_start,
   input  logic [STREAM_W-1:0]    stream_id_in,
   input  logic                   new_stream_in,
   input  logic [NUM_ENGINES-1:0] enable_in,
   input  logic                   byte_vld,
   input  logic [CHAR_W-1:0]      byte_in,
   input  logic                   pkt_end,
   output logic                   load_state,
   output logic [STREAM_W-1:0]    stream_id,
   output logic                   new_stream,
   output logic [NUM_ENGINES-1:0] enable,
   output logic                   char_vld,
   output logic [CHAR_W-1:0]      char_in,
   output logic                   eop,
   output logic                   pkt_done
);

   // First pipeline stage of the byte path
   logic                 vld_s1;
   logic [CHAR_W-1:0]    byte_s1;
   logic                 end_s1;

   // End marker aligned with the last char_vld
   logic                 end_s2;

   // Countdown from the last character to eop
   logic [EOP_CNT_W-1:0] eop_cnt;

   // Packet context, held until pkt_done
   always_ff @(posedge clk)
   begin
      if (pkt_start)
      begin
         stream_id  <= stream_id_in;
         new_stream <= new_stream_in;
      end
   end

   // Control strobes and the two-stage marker pipeline
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         enable     <= '0;
         load_state <= 1'b0;
         vld_s1     <= 1'b0;
         end_s1     <= 1'b0;
         char_vld   <= 1'b0;
         end_s2     <= 1'b0;
      end
      else
      begin
         if (pkt_start)
            enable <= enable_in;
         // Load pulse one cycle after the start strobe
         load_state <= pkt_start;
         vld_s1     <= byte_vld;
         end_s1     <= byte_vld && pkt_end;
         char_vld   <= vld_s1;
         end_s2     <= end_s1;
      end
   end

   // Byte data follows the valid marker without reset
   always_ff @(posedge clk)
   begin
      byte_s1 <= byte_in;
      char_in <= byte_s1;
   end

   // eop three cycles after the last char_vld, done one cycle later
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         eop_cnt  <= '0;
         eop      <= 1'b0;
         pkt_done <= 1'b0;
      end
      else
      begin
         eop      <= (eop_cnt == EOP_CNT_W'(1));
         pkt_done <= eop;
         if (end_s2)
            eop_cnt <= EOP_CNT_W'(EOP_DELAY);
         else if (eop_cnt != '0)
            eop_cnt <= eop_cnt - EOP_CNT_W'(1);
      end
   end

endmodule

// File: verilog/content_scan_top.sv
module content_scan_top
   import scan_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pkt_start,
   input  logic [STREAM_W-1:0]    stream_id,
   input  logic                   new_stream,
   input  logic [NUM_ENGINES-1:0] engine_enable,
   input  logic                   byte_vld,
   input  logic [CHAR_W-1:0]      byte_in,
   input  logic                   pkt_end,
   output logic                   pkt_done,
   output logic                   fired_a,
   output logic                   fired_b,
   output logic [COUNT_W-1:0]     count_a,
   output logic [COUNT_W-1:0]     count_b
);

   // Aligned packet signals shared by both engines
   logic                   fr_load_state;
   logic [STREAM_W-1:0]    fr_stream_id;
   logic                   fr_new_stream;
   logic [NUM_ENGINES-1:0] fr_enable;
   logic                   fr_char_vld;
   logic [CHAR_W-1:0]      fr_char_in;
   logic                   fr_eop;

   packet_framer framer0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .pkt_start     (pkt_start),
      .stream_id_in  (stream_id),
      .new_stream_in (new_stream),
      .enable_in     (engine_enable),
      .byte_vld      (byte_vld),
      .byte_in       (byte_in),
      .pkt_end       (pkt_end),
      .load_state    (fr_load_state),
      .stream_id     (fr_stream_id),
      .new_stream    (fr_new_stream),
      .enable        (fr_enable),
      .char_vld      (fr_char_vld),
      .char_in       (fr_char_in),
      .eop           (fr_eop),
      .pkt_done      (pkt_done)
   );

   // Engine A on enable bit 0
   stream_context_scanner #(
      .PATTERN (PATTERN_A),
      .PAT_LEN (PATTERN_A_LEN)
   ) scan_a (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (fr_load_state),
      .new_stream (fr_new_stream),
      .stream_id  (fr_stream_id),
      .char_in    (fr_char_in),
      .char_vld   (fr_char_vld),
      .eop        (fr_eop),
      .enable     (fr_enable[0]),
      .count      (count_a),
      .fired      (fired_a)
   );

   // Engine B on enable bit 1
   stream_context_scanner #(
      .PATTERN (PATTERN_B),
      .PAT_LEN (PATTERN_B_LEN)
   ) scan_b (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (fr_load_state),
      .new_stream (fr_new_stream),
      .stream_id  (fr_stream_id),
      .char_in    (fr_char_in),
      .char_vld   (fr_char_vld),
      .eop        (fr_eop),
      .enable     (fr_enable[1]),
      .count      (count_b),
      .fired      (fired_b)
   );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free running 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held low over the first four rising edges
   // Released just after the fourth edge, like any other input
   initial
   begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #2 rst_n = 1'b1;
   end

endmodule

// File: testbench/content_scan_assertions.sv
module content_scan_assertions
   import scan_pkg::*;
#(
   parameter bit HAS_COUNT = 1'b1
)
(
   input logic               clk,
   input logic               rst_n,
   input logic               load_state,
   input logic               char_vld,
   input logic               eop,
   input logic [COUNT_W-1:0] count
);

   timeunit 1ns;
   timeprecision 100ps;

   // Number of assertion failures seen by this instance
   int fail_count = 0;

   // No character in the load cycle
   no_char_at_load: assert property (
      @(posedge clk) disable iff (!rst_n) load_state |-> !char_vld)
   else
   begin
      $error("char_vld was high in the same cycle as load_state");
      fail_count++;
   end

   // Restore still in flight one cycle after the load
   no_char_after_load: assert property (
      @(posedge clk) disable iff (!rst_n) load_state |=> !char_vld)
   else
   begin
      $error("char_vld was high in the cycle after load_state");
      fail_count++;
   end

   // eop must trail the last character
   no_char_at_eop: assert property (
      @(posedge clk) disable iff (!rst_n) eop |-> !char_vld)
   else
   begin
      $error("eop was high together with char_vld");
      fail_count++;
   end

   // Counter cleared by reset, only where the bound module keeps one
   if (HAS_COUNT)
   begin : g_count
      count_zero_after_reset: assert property (
         @(posedge clk) !rst_n |=> (count == '0))
      else
      begin
         $error("count was not zero in the cycle after reset");
         fail_count++;
      end
   end

endmodule

// Framer has no counter, so the count check is left out there
bind packet_framer content_scan_assertions #(
   .HAS_COUNT (1'b0)
) fr_chk (
   .clk        (clk),
   .rst_n      (rst_n),
   .load_state (load_state),
   .char_vld   (char_vld),
   .eop        (eop),
   .count      ('0)
);

bind stream_context_scanner content_scan_assertions sc_chk (
   .clk        (clk),
   .rst_n      (rst_n),
   .load_state (load_state),
   .char_vld   (char_vld),
   .eop        (eop),
   .count      (count)
);

// File: testbench/content_scan_tb.sv
module content_scan_tb
   import scan_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_ROWS = 16;
   localparam int MAX_BYTES = 12;
   // Watchdog limit scales with the table
   localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

   logic                   clk;
   logic                   rst_n;
   logic                   pkt_start;
   logic [STREAM_W-1:0]    stream_id;
   logic                   new_stream;
   logic [NUM_ENGINES-1:0] engine_enable;
   logic                   byte_vld;
   logic [CHAR_W-1:0]      byte_in;
   logic                   pkt_end;
   logic                   pkt_done;
   logic                   fired_a;
   logic                   fired_b;
   logic [COUNT_W-1:0]     count_a;
   logic [COUNT_W-1:0]     count_b;

   // Packet table, payload right aligned with the first byte on top
   logic [STREAM_W-1:0]         row_stream [NUM_ROWS];
   logic                        row_new    [NUM_ROWS];
   logic [NUM_ENGINES-1:0]      row_en     [NUM_ROWS];
   logic [CHAR_W*MAX_BYTES-1:0] row_data   [NUM_ROWS];
   int                          row_len    [NUM_ROWS];
   logic                        row_fa     [NUM_ROWS];
   logic                        row_fb     [NUM_ROWS];
   logic [COUNT_W-1:0]          row_ca     [NUM_ROWS];
   logic [COUNT_W-1:0]          row_cb     [NUM_ROWS];
   int                          n_rows;

   int          errors;
   int          cycle_count;
   logic [31:0] rng;

   tb_clock_gen clk_gen0 (
      .clk   (clk),
      .rst_n (rst_n)
   );

   content_scan_top dut0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .pkt_start     (pkt_start),
      .stream_id     (stream_id),
      .new_stream    (new_stream),
      .engine_enable (engine_enable),
      .byte_vld      (byte_vld),
      .byte_in       (byte_in),
      .pkt_end       (pkt_end),
      .pkt_done      (pkt_done),
      .fired_a       (fired_a),
      .fired_b       (fired_b),
      .count_a       (count_a),
      .count_b       (count_b)
   );

   // 32-bit xorshift step
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_row(input logic [STREAM_W-1:0] sid, input logic nw,
                          input logic [NUM_ENGINES-1:0] en,
                          input logic [CHAR_W*MAX_BYTES-1:0] data, input int len,
                          input logic fa, input logic fb,
                          input logic [COUNT_W-1:0] ca, input logic [COUNT_W-1:0] cb);
      row_stream[n_rows] = sid;
      row_new[n_rows]    = nw;
      row_en[n_rows]     = en;
      row_data[n_rows]   = data;
      row_len[n_rows]    = len;
      row_fa[n_rows]     = fa;
      row_fb[n_rows]     = fb;
      row_ca[n_rows]     = ca;
      row_cb[n_rows]     = cb;
      n_rows++;
   endtask

   // Expected counts are running totals over the whole table
   task automatic build_table();
      n_rows = 0;
      // Single packet match on engine A
      add_row(1, 1, 2'b11, "GET /index", 10, 1, 0, 1, 0);
      // "evil" split over two packets of stream 2
      add_row(2, 1, 2'b11, "xxev", 4, 0, 0, 1, 0);
      add_row(2, 0, 2'b11, "il!", 3, 0, 1, 1, 1);
      // Same split, but the second half restarts the stream
      add_row(4, 1, 2'b11, "zzev", 4, 0, 0, 1, 1);
      add_row(4, 1, 2'b11, "il", 2, 0, 0, 1, 1);
      // Engine B off for a matching packet that ends in a partial match
      add_row(5, 1, 2'b11, "ok", 2, 0, 0, 1, 1);
      add_row(5, 0, 2'b01, "evil ev", 7, 0, 0, 1, 1);
      add_row(5, 0, 2'b11, "il", 2, 0, 0, 1, 1);
      // Engine A off for a matching packet
      add_row(6, 1, 2'b10, "GET ", 4, 0, 0, 1, 1);
      // Two interleaved streams, each finishing "GET " later
      add_row(7, 1, 2'b11, "GE", 2, 0, 0, 1, 1);
      add_row(8, 1, 2'b11, "xG", 2, 0, 0, 1, 1);
      add_row(7, 0, 2'b11, "T ", 2, 1, 0, 2, 1);
      add_row(8, 0, 2'b11, "ET ", 3, 1, 0, 3, 1);
      // Restart after a repeated first character, and a double hit
      add_row(9, 1, 2'b11, "GGET ", 5, 1, 0, 4, 1);
      add_row(9, 0, 2'b11, "GET GET ", 8, 1, 0, 5, 1);
      // Both engines in one full length packet
      add_row(10, 1, 2'b11, "GET evil now", 12, 1, 1, 6, 2);
   endtask

   // Advance to just after the next rising edge
   task automatic step_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic compare_outputs(input string tag, input logic fa, input logic fb,
                                  input logic [COUNT_W-1:0] ca,
                                  input logic [COUNT_W-1:0] cb);
      assert (fired_a === fa)
      else
      begin
         $display("error %0t: %s fired_a=%0b expected %0b", $time, tag, fired_a, fa);
         errors++;
      end
      assert (fired_b === fb)
      else
      begin
         $display("error %0t: %s fired_b=%0b expected %0b", $time, tag, fired_b, fb);
         errors++;
      end
      assert (count_a === ca)
      else
      begin
         $display("error %0t: %s count_a=%0d expected %0d", $time, tag, count_a, ca);
         errors++;
      end
      assert (count_b === cb)
      else
      begin
         $display("error %0t: %s count_b=%0d expected %0d", $time, tag, count_b, cb);
         errors++;
      end
   endtask

   // Start strobe, then the payload with random idle gaps
   task automatic send_packet(input int r);
      int i;
      int gap;
      pkt_start     = 1'b1;
      stream_id     = row_stream[r];
      new_stream    = row_new[r];
      engine_enable = row_en[r];
      step_cycle();
      pkt_start = 1'b0;
      for (i = 0; i < row_len[r]; i++)
      begin
         byte_vld = 1'b1;
         byte_in  = row_data[r][CHAR_W*(row_len[r]-1-i) +: CHAR_W];
         pkt_end  = (i == row_len[r] - 1);
         step_cycle();
         byte_vld = 1'b0;
         pkt_end  = 1'b0;
         if (i != row_len[r] - 1)
         begin
            rng = xorshift32(rng);
            gap = rng % 3;
            repeat (gap) step_cycle();
         end
      end
   endtask

   task automatic wait_done();
      while (pkt_done !== 1'b1)
         step_cycle();
   endtask

   // Watchdog
   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run timed out after %0d cycles without finishing the table", cycle_count);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      int r;
      int assert_errors;
      errors        = 0;
      rng           = 32'h4dbe;
      pkt_start     = 1'b0;
      stream_id     = '0;
      new_stream    = 1'b0;
      engine_enable = '0;
      byte_vld      = 1'b0;
      byte_in       = '0;
      pkt_end       = 1'b0;
      build_table();

      @(posedge rst_n);
      step_cycle();
      // Idle state straight after reset
      compare_outputs("after reset", 1'b0, 1'b0, '0, '0);

      for (r = 0; r < n_rows; r++)
      begin
         send_packet(r);
         wait_done();
         compare_outputs($sformatf("row %0d", r), row_fa[r], row_fb[r], row_ca[r], row_cb[r]);
      end

      // Failures from the bound checkers
      assert_errors = dut0.framer0.fr_chk.fail_count + dut0.scan_a.sc_chk.fail_count
                      + dut0.scan_b.sc_chk.fail_count;
      $display("Check errors: %0d, assertion errors: %0d", errors, assert_errors);
      if (errors == 0 && assert_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: sim.f
verilog/scan_pkg.sv
verilog/literal_dfa.sv
verilog/stream_context_scanner.sv
verilog/packet_framer.sv
verilog/content_scan_top.sv
testbench/tb_clock_gen.sv
testbench/content_scan_assertions.sv
testbench/content_scan_tb.sv
